// ==== files.f ====
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_apb_regs.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
dv/uart_properties.sv
dv/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module uart_tb -f files.f \
  -o uart_sim \
  && ./obj_dir/uart_sim 2>&1 | tee sim.log \
  || { echo "build or run failed"; exit 1; }
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"

// ==== dv/uart_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
//==========================================================================
// UART testbench
// APB driver, serial line monitor and driver, reference frame model and
// compare tasks for registers, framing, loopback, parity errors and
// FIFO flow
//==========================================================================

module uart_tb
  import uart_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int DRV         = 5;            // input skew after rising edge
  localparam int TEST_DIV    = 4;            // five clocks per bit
  localparam int NUM_FRAMES  = 50;
  localparam int MAX_FRAME   = 12;           // start, 8 data, parity, 2 stop
  localparam int WATCHDOG_NS = NUM_FRAMES * MAX_FRAME * (TEST_DIV + 1) * CLK_PERIOD
                               + 400_000;    // room for register traffic

  logic        clk;
  logic        rstn;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  logic        tx_line;
  logic        rx_line;
  logic        loop_sel;                     // 1 feeds tx_o back into rx_i
  logic        drv_rx;                       // serial driver output
  integer      seed;
  int          fail_count;
  int          frames_seen;
  logic        cur_par;                      // config the monitor decodes with
  bits_t       cur_bits;
  logic        cur_stop2;
  div_t        cur_div;
  uart_data_t  exp_q[$];                     // bytes queued for sending
  uart_data_t  loop_q[$];
  logic [11:0] obs_q[$];                     // frames seen on tx_o

  assign rx_line = loop_sel ? tx_line : drv_rx;

  uart_top dut (
    .clk_i(clk), .rstn_i(rstn), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .rx_i(rx_line), .tx_o(tx_line)
  );

  bind uart_top uart_properties u_props (
    .clk_i(clk_i), .rstn_i(rstn_i), .psel_i(psel_i), .penable_i(penable_i),
    .pready_i(pready_o), .pslverr_i(pslverr_o), .tx_i(tx_o), .cfg_en_i(cfg_en)
  );

  // line bits in order from bit 0 with ones past the end
  function automatic logic [11:0] frame_bits(input uart_data_t data, input bits_t code,
                                             input logic par_en, input logic stop2,
                                             output int len);
    logic [11:0] seq;
    logic        par;
    int          nbits;
    seq    = '1;
    par    = 1'b0;
    nbits  = 5 + int'(code);
    seq[0] = 1'b0;                           // start
    for (int i = 0; i < nbits; i++) begin
      seq[1 + i] = data[i];
      par        = par ^ data[i];            // even parity over data
    end
    len = 1 + nbits;
    if (par_en) begin
      seq[len] = par;
      len++;
    end
    len += stop2 ? 2 : 1;                    // stop bits already high
    return seq;
  endfunction

  function automatic uart_data_t mask_width(input uart_data_t data, input bits_t code);
    uart_data_t m;
    m = '0;
    for (int i = 0; i < 5 + int'(code); i++) begin
      m[i] = 1'b1;
    end
    return data & m;
  endfunction

  task automatic end_in_failure();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("** Error %s got 0x%h expected 0x%h", name, got, exp);
      fail_count++;
      end_in_failure();
    end
  endtask

  task automatic check_data(input string name, input uart_data_t got, input uart_data_t exp);
    if (got !== exp) begin
      $display("** Error %s got 0x%h expected 0x%h", name, got, exp);
      fail_count++;
      end_in_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error %s got 0x%h expected 0x%h", name, got, exp);
      fail_count++;
      end_in_failure();
    end
  endtask

  // entered and left at DRV after a rising edge
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;                          // setup phase
    penable = 1'b0;
    @(posedge clk);
    #DRV;
    penable = 1'b1;                          // access phase
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    rdata = prdata;                          // sampled mid-cycle
    err   = pslverr;
    @(posedge clk);
    #DRV;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rd;
    logic      err;
    apb_access(1'b1, addr, data, rd, err);
    check_bit("pslverr", err, 1'b0);
  endtask

  task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_bit("pslverr", err, 1'b0);
  endtask

  task automatic set_ctrl(input logic en, input logic par, input bits_t code,
                          input logic stop2);
    cur_par   = par;
    cur_bits  = code;
    cur_stop2 = stop2;
    write_reg(ADDR_CTRL, {27'd0, stop2, code, par, en});
  endtask

  task automatic send_byte(input uart_data_t d);
    write_reg(ADDR_TXDATA, {24'd0, d});
    exp_q.push_back(d);
  endtask

  // fifo drained and last stop bit done
  task automatic wait_tx_idle();
    apb_data_t st;
    st = '0;
    while (!(st[1] && !st[4])) begin
      read_reg(ADDR_STATUS, st);
    end
  endtask

  task automatic wait_rx_data();
    apb_data_t st;
    st = 32'h4;
    while (st[2]) begin
      read_reg(ADDR_STATUS, st);
    end
  endtask

  task automatic drive_frame(input logic [11:0] seq, input int len);
    for (int i = 0; i < len; i++) begin
      drv_rx = seq[i];
      repeat (int'(cur_div) + 1) @(posedge clk);
      #DRV;
    end
    drv_rx = 1'b1;
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    end_in_failure();
  end

  // samples each bit a quarter clock past its centre to stay clear of the edges
  initial begin : serial_monitor
    logic [11:0] seq;
    int          len;
    int          bit_ns;
    forever begin
      @(negedge tx_line);
      seq    = frame_bits('0, cur_bits, cur_par, cur_stop2, len);  // length only
      seq    = '1;
      bit_ns = (int'(cur_div) + 1) * CLK_PERIOD;
      #(bit_ns / 2 + CLK_PERIOD / 4);
      for (int i = 0; i < len; i++) begin
        seq[i] = tx_line;
        if (i < len - 1) begin
          #(bit_ns);
        end
      end
      obs_q.push_back(seq);
    end
  end

  initial begin : frame_compare
    logic [11:0] seq;
    logic [11:0] ref_seq;
    uart_data_t  d;
    int          len;
    forever begin
      @(posedge clk);
      if (obs_q.size() > 0) begin
        seq = obs_q.pop_front();
        if (exp_q.size() == 0) begin
          $display("a frame appeared on tx_o with no byte queued for it");
          end_in_failure();
        end else begin
          d       = exp_q.pop_front();
          ref_seq = frame_bits(d, cur_bits, cur_par, cur_stop2, len);
          check_word("tx_o frame", {20'd0, seq}, {20'd0, ref_seq});
          frames_seen++;
        end
      end
    end
  end

  initial begin : stimulus
    apb_data_t   rd;
    logic        err;
    uart_data_t  d;
    logic [11:0] seq;
    int          len;
    int          base;
    seed        = 32'h0106_d0b8;
    fail_count  = 0;
    frames_seen = 0;
    rstn        = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    loop_sel    = 1'b0;
    drv_rx      = 1'b1;                      // idle line
    cur_par     = 1'b0;
    cur_bits    = '0;
    cur_stop2   = 1'b0;
    cur_div     = '0;
    repeat (10) @(posedge clk);
    #DRV;
    rstn = 1'b1;
    @(posedge clk);
    #DRV;

    // register access and bus errors
    write_reg(ADDR_CTRL, 32'h0000_001E);
    read_reg(ADDR_CTRL, rd);
    check_word("ctrl", rd, 32'h0000_001E);
    write_reg(ADDR_DIV, 32'hFFFF_A5C3);
    read_reg(ADDR_DIV, rd);
    check_word("div", rd, 32'h0000_A5C3);    // only 16 bits held
    read_reg(ADDR_STATUS, rd);
    check_word("status", rd, 32'h0000_0006); // both fifos empty
    apb_access(1'b0, 5'h14, '0, rd, err);
    check_bit("pslverr", err, 1'b1);
    check_word("prdata", rd, '0);
    apb_access(1'b1, 5'h1C, 32'h1234_5678, rd, err);
    check_bit("pslverr", err, 1'b1);
    check_word("prdata", rd, '0);
    apb_access(1'b1, ADDR_STATUS, 32'hFFFF_FFFF, rd, err);
    check_bit("pslverr", err, 1'b1);
    check_word("prdata", rd, '0);
    apb_access(1'b1, ADDR_RXDATA, 32'h0000_00FF, rd, err);
    check_bit("pslverr", err, 1'b1);
    read_reg(ADDR_STATUS, rd);
    check_word("status", rd, 32'h0000_0006);
    write_reg(ADDR_DIV, apb_data_t'(TEST_DIV));
    cur_div = div_t'(TEST_DIV);

    // framing over all widths, parity and stop settings
    for (int c = 0; c < 16; c++) begin
      base = frames_seen;
      set_ctrl(1'b1, c[2], bits_t'(c[1:0]), c[3]);
      repeat (2) send_byte(uart_data_t'($random(seed)));
      while (frames_seen < base + 2) begin
        @(posedge clk);
      end
      #DRV;
      wait_tx_idle();
    end

    // loopback
    loop_sel = 1'b1;
    set_ctrl(1'b1, 1'b1, 2'd2, 1'b0);
    for (int i = 0; i < 4; i++) begin
      d = uart_data_t'($random(seed));
      loop_q.push_back(d);
      send_byte(d);
    end
    for (int i = 0; i < 4; i++) begin
      wait_rx_data();
      read_reg(ADDR_RXDATA, rd);
      d = loop_q.pop_front();
      check_data("rxdata.data", rd[7:0], mask_width(d, 2'd2));
      check_bit("rxdata.perr", rd[8], 1'b0);
    end
    wait_tx_idle();
    read_reg(ADDR_STATUS, rd);
    check_bit("status.rx_empty", rd[2], 1'b1);
    loop_sel = 1'b0;

    // received frame with a bad parity bit
    set_ctrl(1'b1, 1'b1, 2'd3, 1'b0);
    d      = uart_data_t'($random(seed));
    seq    = frame_bits(d, 2'd3, 1'b1, 1'b0, len);
    seq[9] = ~seq[9];                        // parity follows 8 data bits
    drive_frame(seq, len);
    wait_rx_data();
    read_reg(ADDR_RXDATA, rd);
    check_data("rxdata.data", rd[7:0], d);
    check_bit("rxdata.perr", rd[8], 1'b1);

    // fill while disabled with the line held idle
    set_ctrl(1'b0, 1'b0, 2'd0, 1'b0);
    base = frames_seen;
    repeat (FIFO_DEPTH) send_byte(uart_data_t'($random(seed)));
    write_reg(ADDR_TXDATA, 32'h0000_005A);   // no room left
    read_reg(ADDR_STATUS, rd);
    check_bit("status.tx_full", rd[0], 1'b1);
    check_bit("status.tx_busy", rd[4], 1'b0);
    repeat (40) begin
      @(negedge clk);
      check_bit("tx_o", tx_line, 1'b1);
    end
    check_word("frames_seen", apb_data_t'(frames_seen), apb_data_t'(base));
    @(posedge clk);
    #DRV;
    set_ctrl(1'b1, 1'b0, 2'd0, 1'b0);
    while (frames_seen < base + FIFO_DEPTH) begin
      @(posedge clk);
    end
    #DRV;
    wait_tx_idle();
    read_reg(ADDR_STATUS, rd);
    check_bit("status.tx_empty", rd[1], 1'b1);
    check_bit("status.tx_busy", rd[4], 1'b0);
    check_word("frames_seen", apb_data_t'(frames_seen), apb_data_t'(base + FIFO_DEPTH));

    if (fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("%0d checks failed", fail_count);
      end_in_failure();
    end
  end

endmodule

`default_nettype wire

// ==== dv/uart_properties.sv ====
`timescale 1ns/10ps
`default_nettype none
//==========================================================================
// UART bound assertions
// APB access rules and the serial line level while disabled
//==========================================================================

module uart_properties (
  input logic clk_i,
  input logic rstn_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  input logic tx_i,
  input logic cfg_en_i
);

  pready_high: assert property (@(posedge clk_i) disable iff (!rstn_i) pready_i)
    else $error("pready dropped low");        // zero wait states

  slverr_in_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
    pslverr_i |-> (psel_i && penable_i))
    else $error("pslverr outside an access phase");

  // engines reach idle one clock after enable clears
  idle_when_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !cfg_en_i |=> tx_i)
    else $error("tx_o low while disabled");

endmodule

`default_nettype wire

// ==== design/uart_top.sv ====
`timescale 1ns/10ps
`default_nettype none
//==========================================================================
// UART top level
// APB register block, transmit and receive FIFOs and the two serial
// engines
//==========================================================================

module uart_top
  import uart_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  apb_addr_t paddr_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  input  logic      rx_i,
  output logic      tx_o
);

  logic          cfg_en;
  logic          cfg_parity_en;
  bits_t         cfg_bits;
  logic          cfg_stop2;
  div_t          cfg_div;
  logic          tx_push;
  uart_data_t    tx_wdata;
  uart_data_t    tx_head;
  logic          tx_full;
  logic          tx_empty;
  logic          tx_ready;             // also the tx fifo pop
  logic          tx_busy;
  logic          rx_pop;
  logic          rx_push;
  uart_rx_item_t rx_item;
  uart_rx_item_t rx_head;
  logic          rx_full;
  logic          rx_empty;

  uart_apb_regs u_regs (
    .clk_i, .rstn_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .tx_full_i(tx_full), .tx_empty_i(tx_empty), .rx_empty_i(rx_empty),
    .rx_full_i(rx_full), .tx_busy_i(tx_busy), .rx_item_i(rx_head),
    .cfg_en_o(cfg_en), .cfg_parity_en_o(cfg_parity_en), .cfg_bits_o(cfg_bits),
    .cfg_stop2_o(cfg_stop2), .cfg_div_o(cfg_div),
    .tx_push_o(tx_push), .tx_data_o(tx_wdata), .rx_pop_o(rx_pop)
  );

  // fifo ignores the pop while empty, so ready alone is the pop
  uart_fifo #(.item_t(uart_data_t)) tx_fifo (
    .clk_i, .rstn_i, .push_i(tx_push), .push_data_i(tx_wdata), .pop_i(tx_ready),
    .pop_data_o(tx_head), .full_o(tx_full), .empty_o(tx_empty)
  );

  uart_fifo #(.item_t(uart_rx_item_t)) rx_fifo (
    .clk_i, .rstn_i, .push_i(rx_push), .push_data_i(rx_item), .pop_i(rx_pop),
    .pop_data_o(rx_head), .full_o(rx_full), .empty_o(rx_empty)
  );

  uart_tx u_tx (
    .clk_i, .rstn_i, .cfg_en_i(cfg_en), .cfg_div_i(cfg_div),
    .cfg_parity_en_i(cfg_parity_en), .cfg_bits_i(cfg_bits), .cfg_stop2_i(cfg_stop2),
    .tx_data_i(tx_head), .tx_valid_i(!tx_empty), .tx_ready_o(tx_ready),
    .tx_o, .busy_o(tx_busy)
  );

  uart_rx u_rx (
    .clk_i, .rstn_i, .cfg_en_i(cfg_en), .cfg_div_i(cfg_div),
    .cfg_parity_en_i(cfg_parity_en), .cfg_bits_i(cfg_bits), .cfg_stop2_i(cfg_stop2),
    .rx_i, .rx_valid_o(rx_push), .rx_item_o(rx_item)
  );

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none
//==========================================================================
// UART receiver
// synchronizes rx_i, validates the start bit half a bit after the
// falling edge, samples each later bit at its centre and checks even
// parity. One item is pushed per frame after the first stop sample.
//==========================================================================

module uart_rx
  import uart_pkg::*;
(
  input  logic          clk_i,
  input  logic          rstn_i,
  input  logic          cfg_en_i,
  input  div_t          cfg_div_i,
  input  logic          cfg_parity_en_i,
  input  bits_t         cfg_bits_i,
  input  logic          cfg_stop2_i,
  input  logic          rx_i,
  output logic          rx_valid_o,
  output uart_rx_item_t rx_item_o
);

  logic [1:0]  sync_q;                   // two-flop synchronizer
  logic        rx_s;
  logic        rx_prev;
  logic        fall;
  uart_state_e state_q;
  uart_state_e state_d;
  uart_data_t  shift_q;                  // bits enter at the top
  uart_data_t  data_aligned;
  logic [2:0]  bit_cnt_q;
  logic [2:0]  last_bit;
  logic        par_q;                    // parity of data so far
  logic        perr_q;
  div_t        baud_cnt;
  div_t        sample_at;
  logic        sample;                   // centre of the current bit
  logic        active;

  assign rx_s      = sync_q[1];
  assign fall      = rx_prev & ~rx_s;
  assign active    = (state_q != ST_IDLE);
  assign last_bit  = 3'd4 + {1'b0, cfg_bits_i};
  assign sample_at = (state_q == ST_START) ? (cfg_div_i >> 1) : cfg_div_i;
  assign sample    = active & (baud_cnt == sample_at);

  // right-align narrow characters, zeros above
  assign data_aligned = shift_q >> (2'd3 - cfg_bits_i);

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      sync_q  <= 2'b11;                  // line idles high
      rx_prev <= 1'b1;
    end else begin
      sync_q  <= {sync_q[0], rx_i};
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      baud_cnt <= '0;
    end else if (!active || !cfg_en_i || sample) begin
      baud_cnt <= '0;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (fall) state_d = ST_START;
      end
      ST_START: begin
        if (sample) state_d = rx_s ? ST_IDLE : ST_DATA;  // glitch, give up
      end
      ST_DATA: begin
        if (sample && bit_cnt_q == last_bit) begin
          state_d = cfg_parity_en_i ? ST_PARITY : ST_STOP1;
        end
      end
      ST_PARITY: begin
        if (sample) state_d = ST_STOP1;
      end
      ST_STOP1: begin
        if (sample) state_d = cfg_stop2_i ? ST_STOP2 : ST_IDLE;
      end
      ST_STOP2: begin
        if (sample) state_d = ST_IDLE;   // second stop just waited out
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q    <= ST_IDLE;
      bit_cnt_q  <= '0;
      par_q      <= 1'b0;
      perr_q     <= 1'b0;
      rx_valid_o <= 1'b0;
    end else if (!cfg_en_i) begin
      state_q    <= ST_IDLE;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      rx_valid_o <= (state_q == ST_STOP1) & sample;  // push after stop sample
      if (state_q == ST_IDLE) begin
        bit_cnt_q <= '0;
        par_q     <= 1'b0;
        perr_q    <= 1'b0;
      end else if (sample && state_q == ST_DATA) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        par_q     <= par_q ^ rx_s;
      end else if (sample && state_q == ST_PARITY) begin
        perr_q <= rx_s ^ par_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample && state_q == ST_DATA) begin
      shift_q <= {rx_s, shift_q[7:1]};   // lsb arrives first
    end
    if (sample && state_q == ST_STOP1) begin
      rx_item_o <= '{perr: perr_q, data: data_aligned};
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none
//==========================================================================
// UART transmitter
// sends start bit, 5 to 8 data bits LSB first, optional even parity
// and one or two stop bits. Bit time is cfg_div_i+1 clocks.
//==========================================================================

module uart_tx
  import uart_pkg::*;
(
  input  logic       clk_i,
  input  logic       rstn_i,
  input  logic       cfg_en_i,
  input  div_t       cfg_div_i,
  input  logic       cfg_parity_en_i,
  input  bits_t      cfg_bits_i,
  input  logic       cfg_stop2_i,
  input  uart_data_t tx_data_i,
  input  logic       tx_valid_i,
  output logic       tx_ready_o,
  output logic       tx_o,
  output logic       busy_o
);

  uart_state_e state_q;
  uart_state_e state_d;
  uart_data_t  shift_q;                  // lsb is the bit on the line
  logic [2:0]  bit_cnt_q;
  logic [2:0]  last_bit;                 // index of final data bit
  logic        par_q;                    // running even parity
  div_t        baud_cnt;
  logic        bit_done;                 // one-cycle strobe at end of bit
  logic        active;
  logic        take;                     // valid meets ready

  assign last_bit   = 3'd4 + {1'b0, cfg_bits_i};
  assign active     = (state_q != ST_IDLE);
  assign busy_o     = active;
  assign tx_ready_o = (state_q == ST_IDLE) & cfg_en_i;
  assign take       = tx_valid_i & tx_ready_o;
  assign bit_done   = active & (baud_cnt == cfg_div_i);

  // baud counter, only runs inside a frame
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      baud_cnt <= '0;
    end else if (!active || !cfg_en_i || bit_done) begin
      baud_cnt <= '0;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    tx_o    = 1'b1;                      // idle and stop level
    case (state_q)
      ST_IDLE: begin
        if (take) state_d = ST_START;
      end
      ST_START: begin
        tx_o = 1'b0;
        if (bit_done) state_d = ST_DATA;
      end
      ST_DATA: begin
        tx_o = shift_q[0];
        if (bit_done && bit_cnt_q == last_bit) begin
          state_d = cfg_parity_en_i ? ST_PARITY : ST_STOP1;
        end
      end
      ST_PARITY: begin
        tx_o = par_q;
        if (bit_done) state_d = ST_STOP1;
      end
      ST_STOP1: begin
        if (bit_done) state_d = cfg_stop2_i ? ST_STOP2 : ST_IDLE;
      end
      ST_STOP2: begin
        if (bit_done) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q   <= ST_IDLE;
      bit_cnt_q <= '0;
      par_q     <= 1'b0;
    end else if (!cfg_en_i) begin
      state_q   <= ST_IDLE;              // disable aborts the frame
      bit_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE) begin
        bit_cnt_q <= '0;
        par_q     <= 1'b0;
      end else if (state_q == ST_DATA && bit_done) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        par_q     <= par_q ^ shift_q[0];
      end
    end
  end

  // character register, loaded on the pop and shifted per data bit
  always_ff @(posedge clk_i) begin
    if (take) begin
      shift_q <= tx_data_i;
    end else if (state_q == ST_DATA && bit_done) begin
      shift_q <= {1'b1, shift_q[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_apb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
//==========================================================================
// UART register block
// APB slave with zero wait states. Holds CTRL and DIV, builds STATUS
// from FIFO and engine flags, pushes TXDATA writes into the transmit
// FIFO and pops the receive FIFO on RXDATA reads.
//==========================================================================

module uart_apb_regs
  import uart_pkg::*;
(
  input  logic          clk_i,
  input  logic          rstn_i,
  input  apb_addr_t     paddr_i,
  input  logic          psel_i,
  input  logic          penable_i,
  input  logic          pwrite_i,
  input  apb_data_t     pwdata_i,
  output apb_data_t     prdata_o,
  output logic          pready_o,
  output logic          pslverr_o,
  input  logic          tx_full_i,
  input  logic          tx_empty_i,
  input  logic          rx_empty_i,
  input  logic          rx_full_i,
  input  logic          tx_busy_i,
  input  uart_rx_item_t rx_item_i,
  output logic          cfg_en_o,
  output logic          cfg_parity_en_o,
  output bits_t         cfg_bits_o,
  output logic          cfg_stop2_o,
  output div_t          cfg_div_o,
  output logic          tx_push_o,
  output uart_data_t    tx_data_o,
  output logic          rx_pop_o
);

  logic      acc;                                   // access phase
  logic      wr_acc;
  logic      rd_acc;
  logic      hit_ctrl;
  logic      hit_div;
  logic      hit_status;
  logic      hit_tx;
  logic      hit_rx;
  logic      mapped;
  logic      bad_wr;                                // write to a read-only reg
  apb_data_t status_word;

  assign acc    = psel_i & penable_i;
  assign wr_acc = acc & pwrite_i;
  assign rd_acc = acc & ~pwrite_i;

  assign hit_ctrl   = (paddr_i == ADDR_CTRL);
  assign hit_div    = (paddr_i == ADDR_DIV);
  assign hit_status = (paddr_i == ADDR_STATUS);
  assign hit_tx     = (paddr_i == ADDR_TXDATA);
  assign hit_rx     = (paddr_i == ADDR_RXDATA);
  assign mapped     = hit_ctrl | hit_div | hit_status | hit_tx | hit_rx;
  assign bad_wr     = pwrite_i & (hit_status | hit_rx);

  assign pready_o  = 1'b1;                          // never stalls
  assign pslverr_o = acc & (~mapped | bad_wr);

  // bad accesses fall out of the hit terms, so they touch nothing
  assign tx_push_o = wr_acc & hit_tx & ~tx_full_i;  // dropped when full
  assign tx_data_o = pwdata_i[7:0];
  assign rx_pop_o  = rd_acc & hit_rx & ~rx_empty_i; // no pop when empty

  assign status_word = {27'd0, tx_busy_i, rx_full_i, rx_empty_i, tx_empty_i, tx_full_i};

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cfg_en_o        <= 1'b0;
      cfg_parity_en_o <= 1'b0;
      cfg_bits_o      <= '0;
      cfg_stop2_o     <= 1'b0;
      cfg_div_o       <= '0;
    end else begin
      if (wr_acc && hit_ctrl) begin
        cfg_en_o        <= pwdata_i[CTRL_EN];
        cfg_parity_en_o <= pwdata_i[CTRL_PAR];
        cfg_bits_o      <= pwdata_i[CTRL_BITS +: 2];
        cfg_stop2_o     <= pwdata_i[CTRL_STOP2];
      end
      if (wr_acc && hit_div) begin
        cfg_div_o <= pwdata_i[15:0];                // upper half ignored
      end
    end
  end

  // read data is valid only in the access phase
  always_comb begin
    prdata_o = '0;
    if (rd_acc) begin
      case (paddr_i)
        ADDR_CTRL:   prdata_o = {27'd0, cfg_stop2_o, cfg_bits_o, cfg_parity_en_o, cfg_en_o};
        ADDR_DIV:    prdata_o = {16'd0, cfg_div_o};
        ADDR_STATUS: prdata_o = status_word;
        ADDR_RXDATA: begin
          if (!rx_empty_i) begin
            prdata_o = {23'd0, rx_item_i};          // head before the pop
          end
        end
        default:     prdata_o = '0;                 // txdata and holes
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none
//==========================================================================
// UART FIFO
// circular buffer of FIFO_DEPTH entries with full and empty flags,
// payload chosen by type parameter. Overflowing pushes and pops of
// an empty buffer are ignored.
//==========================================================================

module uart_fifo
  import uart_pkg::*;
#(
  parameter type item_t = uart_data_t
) (
  input  logic  clk_i,
  input  logic  rstn_i,
  input  logic  push_i,
  input  item_t push_data_i,
  input  logic  pop_i,
  output item_t pop_data_o,
  output logic  full_o,
  output logic  empty_o
);

  item_t              mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;             // wraps at depth
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;              // occupancy, one bit wider
  logic               do_push;
  logic               do_pop;

  assign full_o     = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign empty_o    = (count == '0);
  assign do_push    = push_i & ~full_o;
  assign do_pop     = pop_i & ~empty_o;
  assign pop_data_o = mem[rd_ptr];        // head, shown combinationally

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_pkg.sv ====
`default_nettype none
//==========================================================================
// UART shared definitions
// bus and character types, register map, FIFO sizing and the frame
// state encoding used by both serial engines
//==========================================================================

package uart_pkg;

  typedef logic [4:0]  apb_addr_t;      // byte address
  typedef logic [31:0] apb_data_t;
  typedef logic [7:0]  uart_data_t;     // narrow frames use the low bits
  typedef logic [15:0] div_t;           // bit time is div+1 clocks
  typedef logic [1:0]  bits_t;          // code n gives 5+n data bits

  typedef struct packed {
    logic       perr;                   // parity mismatch, bit 8 on the bus
    uart_data_t data;
  } uart_rx_item_t;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;        // log2 of depth

  localparam apb_addr_t ADDR_CTRL   = 5'h00;
  localparam apb_addr_t ADDR_DIV    = 5'h04;
  localparam apb_addr_t ADDR_STATUS = 5'h08;  // read only
  localparam apb_addr_t ADDR_TXDATA = 5'h0C;  // write only
  localparam apb_addr_t ADDR_RXDATA = 5'h10;  // read pops

  localparam int CTRL_EN    = 0;        // ctrl field positions
  localparam int CTRL_PAR   = 1;
  localparam int CTRL_BITS  = 2;        // two bits wide
  localparam int CTRL_STOP2 = 4;

  typedef enum logic [2:0] {
    ST_IDLE   = 3'b110,
    ST_START  = 3'b101,
    ST_DATA   = 3'b100,
    ST_PARITY = 3'b011,
    ST_STOP1  = 3'b010,
    ST_STOP2  = 3'b001
  } uart_state_e;

endpackage

`default_nettype wire
